// File: design/tetris_pkg.sv
package tetris_pkg;

    // ====================
    // Board geometry
    // ====================

    localparam int BOARD_ROWS      = 20;
    localparam int BOARD_COLS      = 10;
    // Left column of the 4x4 box when a piece appears
    localparam int SPAWN_COL       = 3;
    localparam int NUM_SPAWN_TYPES = 7;

    // Row 0 is the top of the board, bit 0 the leftmost column
    typedef logic [BOARD_COLS-1:0] row_t;
    typedef row_t [BOARD_ROWS-1:0] board_t;

    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

    // ====================
    // Piece codes
    // ====================

    // Spawn orientations, codes 7 to 18 are the rotated ones
    typedef logic [4:0] piece_code_t;

    localparam piece_code_t CODE_I   = 5'd0;
    localparam piece_code_t CODE_O   = 5'd1;
    localparam piece_code_t CODE_S   = 5'd2;
    localparam piece_code_t CODE_Z   = 5'd3;
    localparam piece_code_t CODE_J   = 5'd4;
    localparam piece_code_t CODE_L   = 5'd5;
    localparam piece_code_t CODE_T   = 5'd6;
    // No piece in play, blank pattern
    localparam piece_code_t NO_PIECE = 5'd31;

    // Pattern cell [row][col] inside the 4x4 box
    typedef logic [3:0][3:0] pattern_t;

    // ====================
    // Control types
    // ====================

    typedef enum logic [2:0] {
        INIT,
        SPAWN,
        FALLING,
        ROTATE,
        STUCK,
        LANDED,
        EVAL,
        GAMEOVER
    } game_state_t;

    // One-cycle key strobes
    typedef struct packed {
        logic left;
        logic right;
        logic rot_cw;
        logic rot_ccw;
    } key_strobes_t;

    // Top left corner of the 4x4 box
    typedef struct packed {
        row_idx_t y;
        col_idx_t x;
    } piece_pos_t;

    typedef struct packed {
        logic bottom;
        logic left;
        logic right;
        logic rot_fits;
    } collide_t;

endpackage

// File: design/input_sync.sv
`timescale 1ns/1ps

module input_sync
    import tetris_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         left_i,
    input  logic         right_i,
    input  logic         rot_cw_i,
    input  logic         rot_ccw_i,
    input  logic         tick_i,
    output key_strobes_t keys_o,
    output logic         drop_tick_o
);

    // Bit 4 tick, bits 3 to 0 in key struct order
    logic [4:0] raw;
    logic [4:0] sync0_q;
    logic [4:0] sync1_q;
    logic [4:0] prev_q;
    logic [3:0] key_rise;

    assign raw      = {tick_i, left_i, right_i, rot_cw_i, rot_ccw_i};
    assign key_rise = sync1_q[3:0] & ~prev_q[3:0];

    // Two flops, edge detect, then a registered strobe
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            sync0_q     <= '0;
            sync1_q     <= '0;
            prev_q      <= '0;
            keys_o      <= '0;
            drop_tick_o <= 1'b0;
        end else begin
            sync0_q     <= raw;
            sync1_q     <= sync0_q;
            prev_q      <= sync1_q;
            keys_o      <= key_strobes_t'(key_rise);
            // Drop on the falling edge of the slow tick
            drop_tick_o <= prev_q[4] & ~sync1_q[4];
        end
    end

endmodule

// File: design/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl
    import tetris_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start_i,
    input  key_strobes_t keys_i,
    input  logic         drop_tick_i,
    input  collide_t     collide_i,
    input  piece_code_t  next_code_i,
    input  logic         clear_done_i,
    input  logic         row0_busy_i,
    output piece_pos_t   pos_o,
    output piece_code_t  code_o,
    output logic         rot_ccw_o,
    output logic         land_o,
    output logic         start_clear_o,
    output logic         gameover_o
);

    game_state_t state;
    game_state_t state_nxt;

    // Free-running spawn counter
    logic [2:0]  spawn_cnt;

    piece_pos_t  pos_q;
    piece_code_t code_q;
    logic        rot_ccw_q;
    logic        rot_req;

    // O piece has a single orientation
    assign rot_req = (keys_i.rot_cw | keys_i.rot_ccw) & (code_q != CODE_O);

    // ====================
    // State machine
    // ====================

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= INIT;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            INIT:     if (start_i) state_nxt = SPAWN;
            SPAWN:    state_nxt = FALLING;
            FALLING: begin
                // Lock on the first tick that finds the piece resting
                if (drop_tick_i && collide_i.bottom) begin
                    state_nxt = STUCK;
                end else if (!drop_tick_i && rot_req) begin
                    state_nxt = ROTATE;
                end
            end
            ROTATE:   state_nxt = FALLING;
            STUCK:    state_nxt = row0_busy_i ? GAMEOVER : LANDED;
            LANDED:   state_nxt = EVAL;
            EVAL:     if (clear_done_i) state_nxt = SPAWN;
            GAMEOVER: state_nxt = GAMEOVER;
            default:  state_nxt = INIT;
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            spawn_cnt <= '0;
        end else if (spawn_cnt == 3'(NUM_SPAWN_TYPES - 1)) begin
            spawn_cnt <= '0;
        end else begin
            spawn_cnt <= spawn_cnt + 3'd1;
        end
    end

    // ====================
    // Piece registers
    // ====================

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pos_q     <= '0;
            code_q    <= NO_PIECE;
            rot_ccw_q <= 1'b0;
        end else begin
            case (state)
                SPAWN: begin
                    pos_q.y <= '0;
                    pos_q.x <= col_idx_t'(SPAWN_COL);
                    code_q  <= piece_code_t'(spawn_cnt);
                end
                FALLING: begin
                    // Drop tick wins over a sideways move
                    if (drop_tick_i) begin
                        if (!collide_i.bottom) pos_q.y <= pos_q.y + 5'd1;
                    end else if (keys_i.left && !collide_i.left) begin
                        pos_q.x <= pos_q.x - 4'd1;
                    end else if (keys_i.right && !collide_i.right) begin
                        pos_q.x <= pos_q.x + 4'd1;
                    end
                    // Clockwise if both keys come together
                    if (rot_req) rot_ccw_q <= ~keys_i.rot_cw;
                end
                ROTATE:  if (collide_i.rot_fits) code_q <= next_code_i;
                // Piece is now part of the stored board
                STUCK:   code_q <= NO_PIECE;
                default: ;
            endcase
        end
    end

    assign pos_o         = pos_q;
    assign code_o        = code_q;
    assign rot_ccw_o     = rot_ccw_q;
    assign land_o        = (state == STUCK);
    assign start_clear_o = (state == LANDED);
    assign gameover_o    = (state == GAMEOVER);

endmodule

// File: design/piece_rom.sv
`timescale 1ns/1ps

module piece_rom
    import tetris_pkg::*;
(
    input  piece_code_t code_i,
    input  logic        rot_ccw_i,
    output pattern_t    pattern_o,
    output piece_code_t next_code_o,
    output pattern_t    next_pattern_o
);

    // Nibble n is box row n, bit 0 of a nibble the left column
    function automatic pattern_t shape(input piece_code_t code);
        case (code)
            CODE_I:  shape = 16'h2222;
            5'd7:    shape = 16'h00f0;
            CODE_O:  shape = 16'h0066;
            CODE_S:  shape = 16'h0036;
            5'd9:    shape = 16'h0231;
            CODE_Z:  shape = 16'h0063;
            5'd8:    shape = 16'h0132;
            // J quarter turns
            CODE_J:  shape = 16'h0071;
            5'd10:   shape = 16'h0226;
            5'd11:   shape = 16'h0470;
            5'd12:   shape = 16'h0322;
            // L quarter turns
            CODE_L:  shape = 16'h0074;
            5'd13:   shape = 16'h0622;
            5'd14:   shape = 16'h0170;
            5'd15:   shape = 16'h0223;
            // T quarter turns
            CODE_T:  shape = 16'h0072;
            5'd18:   shape = 16'h0262;
            5'd17:   shape = 16'h0270;
            5'd16:   shape = 16'h0232;
            default: shape = '0;
        endcase
    endfunction

    // ====================
    // Rotation successors
    // ====================

    always_comb begin
        next_code_o = code_i;
        case (code_i)
            // Two-state pieces toggle either way
            CODE_I:  next_code_o = 5'd7;
            5'd7:    next_code_o = CODE_I;
            CODE_S:  next_code_o = 5'd9;
            5'd9:    next_code_o = CODE_S;
            CODE_Z:  next_code_o = 5'd8;
            5'd8:    next_code_o = CODE_Z;
            // J cycle 4 10 11 12
            CODE_J:  next_code_o = rot_ccw_i ? 5'd12 : 5'd10;
            5'd10:   next_code_o = rot_ccw_i ? CODE_J : 5'd11;
            5'd11:   next_code_o = rot_ccw_i ? 5'd10 : 5'd12;
            5'd12:   next_code_o = rot_ccw_i ? 5'd11 : CODE_J;
            // L cycle 5 13 14 15
            CODE_L:  next_code_o = rot_ccw_i ? 5'd15 : 5'd13;
            5'd13:   next_code_o = rot_ccw_i ? CODE_L : 5'd14;
            5'd14:   next_code_o = rot_ccw_i ? 5'd13 : 5'd15;
            5'd15:   next_code_o = rot_ccw_i ? 5'd14 : CODE_L;
            // T cycle 6 18 17 16
            CODE_T:  next_code_o = rot_ccw_i ? 5'd16 : 5'd18;
            5'd18:   next_code_o = rot_ccw_i ? CODE_T : 5'd17;
            5'd17:   next_code_o = rot_ccw_i ? 5'd18 : 5'd16;
            5'd16:   next_code_o = rot_ccw_i ? 5'd17 : CODE_T;
            default: next_code_o = code_i;
        endcase
    end

    assign pattern_o      = shape(code_i);
    assign next_pattern_o = shape(next_code_o);

endmodule

// File: design/board_store.sv
`timescale 1ns/1ps

module board_store
    import tetris_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  piece_pos_t pos_i,
    input  pattern_t   pattern_i,
    input  pattern_t   next_pattern_i,
    input  logic       land_i,
    input  board_t     cleared_i,
    input  logic       clear_done_i,
    output board_t     board_o,
    output collide_t   collide_o,
    output logic       row0_busy_o,
    output board_t     display_o
);

    localparam row_idx_t LAST_ROW = row_idx_t'(BOARD_ROWS - 1);
    localparam col_idx_t LAST_COL = col_idx_t'(BOARD_COLS - 1);

    board_t stored_q;
    // Falling piece placed on an empty board
    board_t overlay;

    // Landed piece merges in, compacted board replaces all
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            stored_q <= '0;
        end else if (land_i) begin
            stored_q <= stored_q | overlay;
        end else if (clear_done_i) begin
            stored_q <= cleared_i;
        end
    end

    // ====================
    // Overlay and checks
    // ====================

    always_comb begin
        row_idx_t ar;
        col_idx_t ac;
        overlay            = '0;
        collide_o          = '0;
        collide_o.rot_fits = 1'b1;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                // Column wraps modulo 16, so a box left of column 0 reads as off board
                ar = pos_i.y + row_idx_t'(r);
                ac = pos_i.x + col_idx_t'(c);
                if (pattern_i[r][c] && ar <= LAST_ROW && ac <= LAST_COL) begin
                    overlay[ar][ac] = 1'b1;
                    // Floor or stored cell below
                    if (ar == LAST_ROW) begin
                        collide_o.bottom = 1'b1;
                    end else if (stored_q[ar + 5'd1][ac]) begin
                        collide_o.bottom = 1'b1;
                    end
                    // Walls and side neighbours
                    if (ac == '0) begin
                        collide_o.left = 1'b1;
                    end else if (stored_q[ar][ac - 4'd1]) begin
                        collide_o.left = 1'b1;
                    end
                    if (ac == LAST_COL) begin
                        collide_o.right = 1'b1;
                    end else if (stored_q[ar][ac + 4'd1]) begin
                        collide_o.right = 1'b1;
                    end
                end
                // Rotated cells must be on the board and free
                if (next_pattern_i[r][c]) begin
                    if (ar > LAST_ROW || ac > LAST_COL) begin
                        collide_o.rot_fits = 1'b0;
                    end else if (stored_q[ar][ac]) begin
                        collide_o.rot_fits = 1'b0;
                    end
                end
            end
        end
    end

    assign board_o     = stored_q;
    assign display_o   = stored_q | overlay;
    // Top row after the piece merges
    assign row0_busy_o = |display_o[0];

endmodule

// File: design/line_clear.sv
`timescale 1ns/1ps

module line_clear
    import tetris_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start_i,
    input  board_t     board_i,
    output board_t     board_o,
    output logic       done_o,
    output logic [9:0] score_o
);

    board_t      src_q;
    board_t      dst_q;
    logic        busy_q;
    // Read walks every row, write only on kept rows
    row_idx_t    rd_row_q;
    row_idx_t    wr_row_q;
    logic [4:0]  cnt_q;
    logic        row_full;
    logic [4:0]  cnt_nxt;
    logic [10:0] score_sum;

    assign row_full  = &src_q[rd_row_q];
    assign cnt_nxt   = cnt_q + 5'(row_full);
    assign score_sum = {1'b0, score_o} + 11'(cnt_nxt);

    // ====================
    // Compaction
    // ====================

    always_ff @(posedge clk) begin
        if (start_i) begin
            src_q <= board_i;
            dst_q <= '0;
        end else if (busy_q && !row_full) begin
            dst_q[wr_row_q] <= src_q[rd_row_q];
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            busy_q   <= 1'b0;
            done_o   <= 1'b0;
            rd_row_q <= '0;
            wr_row_q <= '0;
            cnt_q    <= '0;
            score_o  <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy_q   <= 1'b1;
                rd_row_q <= row_idx_t'(BOARD_ROWS - 1);
                wr_row_q <= row_idx_t'(BOARD_ROWS - 1);
                cnt_q    <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_nxt;
                if (rd_row_q == '0) begin
                    // Top row done, score saturates
                    busy_q  <= 1'b0;
                    done_o  <= 1'b1;
                    score_o <= (score_sum > 11'd1023) ? 10'd1023 : score_sum[9:0];
                end else begin
                    rd_row_q <= rd_row_q - 5'd1;
                    if (!row_full) wr_row_q <= wr_row_q - 5'd1;
                end
            end
        end
    end

    assign board_o = dst_q;

endmodule

// File: design/tetris_top.sv
`timescale 1ns/1ps

module tetris_top
    import tetris_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start_i,
    input  logic       left_i,
    input  logic       right_i,
    input  logic       rot_cw_i,
    input  logic       rot_ccw_i,
    input  logic       tick_i,
    output board_t     display_o,
    output logic [9:0] score_o,
    output logic       gameover_o
);

    // Synchronised strobes
    key_strobes_t keys;
    logic         drop_tick;

    // Piece state from the controller
    piece_pos_t   pos;
    piece_code_t  code;
    piece_code_t  next_code;
    logic         rot_ccw;

    // Patterns and board status
    pattern_t     pattern;
    pattern_t     next_pattern;
    collide_t     collide;
    logic         row0_busy;

    // Landing and line clear handshake strobes
    logic         land;
    logic         start_clear;
    logic         clear_done;
    board_t       board;
    board_t       cleared;

    input_sync i_sync (
        .clk         (clk),
        .reset       (reset),
        .left_i      (left_i),
        .right_i     (right_i),
        .rot_cw_i    (rot_cw_i),
        .rot_ccw_i   (rot_ccw_i),
        .tick_i      (tick_i),
        .keys_o      (keys),
        .drop_tick_o (drop_tick)
    );

    game_ctrl i_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start_i       (start_i),
        .keys_i        (keys),
        .drop_tick_i   (drop_tick),
        .collide_i     (collide),
        .next_code_i   (next_code),
        .clear_done_i  (clear_done),
        .row0_busy_i   (row0_busy),
        .pos_o         (pos),
        .code_o        (code),
        .rot_ccw_o     (rot_ccw),
        .land_o        (land),
        .start_clear_o (start_clear),
        .gameover_o    (gameover_o)
    );

    piece_rom i_rom (
        .code_i         (code),
        .rot_ccw_i      (rot_ccw),
        .pattern_o      (pattern),
        .next_code_o    (next_code),
        .next_pattern_o (next_pattern)
    );

    board_store i_board (
        .clk            (clk),
        .reset          (reset),
        .pos_i          (pos),
        .pattern_i      (pattern),
        .next_pattern_i (next_pattern),
        .land_i         (land),
        .cleared_i      (cleared),
        .clear_done_i   (clear_done),
        .board_o        (board),
        .collide_o      (collide),
        .row0_busy_o    (row0_busy),
        .display_o      (display_o)
    );

    line_clear i_clear (
        .clk     (clk),
        .reset   (reset),
        .start_i (start_clear),
        .board_i (board),
        .board_o (cleared),
        .done_o  (clear_done),
        .score_o (score_o)
    );

endmodule

// File: testbench/tetris_sva.sv
`timescale 1ns/1ps

module tetris_sva (
    input logic       clk,
    input logic       reset,
    input logic       land_i,
    input logic       start_clear_i,
    input logic       gameover_i,
    input logic [9:0] score_i
);

    // Game over holds until reset
    gameover_held: assert property (@(posedge clk) disable iff (reset) !$fell(gameover_i))
        else $error("gameover fell without reset");

    // STUCK and LANDED are different states
    land_clear_apart: assert property (@(posedge clk) disable iff (reset)
        !(land_i && start_clear_i))
        else $error("land and start_clear high together");

    // Score only counts up
    score_rises: assert property (@(posedge clk) disable iff (reset)
        score_i >= $past(score_i))
        else $error("score decreased");

endmodule

bind tetris_top tetris_sva i_sva (
    .clk           (clk),
    .reset         (reset),
    .land_i        (land),
    .start_clear_i (start_clear),
    .gameover_i    (gameover_o),
    .score_i       (score_o)
);

// File: testbench/tb_tetris.sv
`timescale 1ns/1ps

module tb_tetris
    import tetris_pkg::*;
();

    // Run limits
    localparam int MAX_PIECES = 200;
    localparam int MAX_CYCLES = MAX_PIECES * 600;
    // Pieces that get rotated and steered before plain centre stacking
    localparam int STEERED    = 40;

    // One press is 4 cycles held and 8 released
    localparam int PRESS_CYCLES  = 4 + 8;
    // Tick falls 4 cycles in, drop strobe 3 cycles later, lock on the next edge
    localparam int LOCK_CYCLE    = 4 + 3 + 1;
    // Land strobe to the next spawn
    localparam int LAND_TO_SPAWN = 23;

    logic       clk;
    logic       reset;
    logic       start;
    logic       left;
    logic       right;
    logic       rot_cw;
    logic       rot_ccw;
    logic       tick;
    board_t     display;
    logic [9:0] score;
    logic       gameover;

    // Reference model state
    board_t model;
    board_t exp_display;
    int     exp_score;
    logic   exp_gameover;
    logic   live;
    int     pc_code;
    int     pc_x;
    int     pc_y;

    int     errors;
    int     checks;
    int     cycles;
    integer seed;
    logic   check_req;

    // Box columns to steer toward, in turn
    int targets [10] = '{-1, 1, 3, 5, 7, 0, 2, 4, 6, 8};

    tetris_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .start_i    (start),
        .left_i     (left),
        .right_i    (right),
        .rot_cw_i   (rot_cw),
        .rot_ccw_i  (rot_ccw),
        .tick_i     (tick),
        .display_o  (display),
        .score_o    (score),
        .gameover_o (gameover)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ====================
    // Reference functions
    // ====================

    // Nibble n is box row n, bit 0 the left column
    function automatic pattern_t ref_shape(input int code);
        case (code)
            0:       return 16'h2222;
            1:       return 16'h0066;
            2:       return 16'h0036;
            3:       return 16'h0063;
            4:       return 16'h0071;
            5:       return 16'h0074;
            6:       return 16'h0072;
            7:       return 16'h00f0;
            8:       return 16'h0132;
            9:       return 16'h0231;
            10:      return 16'h0226;
            11:      return 16'h0470;
            12:      return 16'h0322;
            13:      return 16'h0622;
            14:      return 16'h0170;
            15:      return 16'h0223;
            16:      return 16'h0232;
            17:      return 16'h0270;
            18:      return 16'h0262;
            default: return '0;
        endcase
    endfunction

    // Clockwise successor, counter-clockwise goes the other way round
    function automatic int ref_next(input int code, input logic ccw);
        case (code)
            0:       return 7;
            7:       return 0;
            2:       return 9;
            9:       return 2;
            3:       return 8;
            8:       return 3;
            4:       return ccw ? 12 : 10;
            10:      return ccw ? 4 : 11;
            11:      return ccw ? 10 : 12;
            12:      return ccw ? 11 : 4;
            5:       return ccw ? 15 : 13;
            13:      return ccw ? 5 : 14;
            14:      return ccw ? 13 : 15;
            15:      return ccw ? 14 : 5;
            6:       return ccw ? 16 : 18;
            18:      return ccw ? 6 : 17;
            17:      return ccw ? 18 : 16;
            16:      return ccw ? 17 : 6;
            default: return code;
        endcase
    endfunction

    // Piece cells on an empty board, cells off the board dropped
    function automatic board_t place(input int code, input int x, input int y);
        board_t   b;
        pattern_t p;
        b = '0;
        p = ref_shape(code);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (p[r][c] && y + r < BOARD_ROWS && x + c >= 0 && x + c < BOARD_COLS)
                    b[y + r][x + c] = 1'b1;
            end
        end
        return b;
    endfunction

    // Any on-board cell whose neighbour at (dy, dx) is a wall or stored
    function automatic logic blocked(input board_t b, input int code, input int x,
                                     input int y, input int dy, input int dx);
        pattern_t p;
        int       nr;
        int       nc;
        p = ref_shape(code);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                nr = y + r + dy;
                nc = x + c + dx;
                if (p[r][c] && y + r < BOARD_ROWS && x + c >= 0 && x + c < BOARD_COLS) begin
                    if (nr >= BOARD_ROWS || nc < 0 || nc >= BOARD_COLS) return 1'b1;
                    if (b[nr][nc]) return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    // Every cell on the board and free
    function automatic logic fits(input board_t b, input int code, input int x, input int y);
        pattern_t p;
        p = ref_shape(code);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (p[r][c]) begin
                    if (y + r >= BOARD_ROWS || x + c < 0 || x + c >= BOARD_COLS) return 1'b0;
                    if (b[y + r][x + c]) return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    // Full rows removed, the rest pushed down
    function automatic board_t compact(input board_t b, output int n);
        board_t res;
        int     w;
        res = '0;
        n   = 0;
        w   = BOARD_ROWS - 1;
        for (int r = BOARD_ROWS - 1; r >= 0; r--) begin
            if (&b[r]) begin
                n++;
            end else begin
                res[w] = b[r];
                w--;
            end
        end
        return res;
    endfunction

    // ====================
    // Checking
    // ====================

    task automatic check_value(input string name, input logic [199:0] got,
                               input logic [199:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Compares on request, then hands control back to the stimulus
    initial begin
        forever begin
            wait (check_req === 1'b1);
            check_value("display_o", display, exp_display);
            check_value("score_o", 200'(score), 200'(exp_score));
            check_value("gameover_o", 200'(gameover), 200'(exp_gameover));
            check_req = 1'b0;
        end
    end

    task automatic post_check;
        exp_display = model;
        if (live) exp_display = exp_display | place(pc_code, pc_x, pc_y);
        check_req = 1'b1;
        wait (check_req === 1'b0);
    endtask

    // ====================
    // Stimulus
    // ====================

    // 0 left, 1 right, 2 clockwise, 3 counter-clockwise, 4 tick
    task automatic drive_line(input int line, input logic v);
        case (line)
            0:       left    = v;
            1:       right   = v;
            2:       rot_cw  = v;
            3:       rot_ccw = v;
            default: tick    = v;
        endcase
    endtask

    task automatic press(input int line);
        drive_line(line, 1'b1);
        repeat (4) @(negedge clk);
        drive_line(line, 1'b0);
        repeat (8) @(negedge clk);
    endtask

    task automatic move_piece(input int dir);
        press(dir < 0 ? 0 : 1);
        if (!blocked(model, pc_code, pc_x, pc_y, 0, dir)) pc_x = pc_x + dir;
        post_check;
    endtask

    task automatic rotate_piece(input logic ccw);
        int n;
        press(ccw ? 3 : 2);
        n = ref_next(pc_code, ccw);
        if (pc_code != 1 && fits(model, n, pc_x, pc_y)) pc_code = n;
        post_check;
    endtask

    // One tick, the piece falls a row or locks into the model
    task automatic drop_piece(output logic landed);
        press(4);
        landed = 1'b0;
        if (!blocked(model, pc_code, pc_x, pc_y, 1, 0)) begin
            pc_y = pc_y + 1;
        end else begin
            model        = model | place(pc_code, pc_x, pc_y);
            live         = 1'b0;
            landed       = 1'b1;
            exp_gameover = |model[0];
        end
        post_check;
    endtask

    task automatic wait_display(input board_t want, input logic equal, output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (n < 60 && !ok) begin
            if ((display === want) == equal) begin
                ok = 1'b1;
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    // New piece must be one spawn pattern with its box at row 0, column 3
    task automatic identify_spawn(output logic ok);
        ok = 1'b0;
        wait_display(model, 1'b0, ok);
        if (!ok) begin
            errors++;
            $display("No new piece appeared on the display");
        end else begin
            ok = 1'b0;
            for (int k = 0; k < NUM_SPAWN_TYPES; k++) begin
                if (!ok && display === (model | place(k, SPAWN_COL, 0))) begin
                    ok      = 1'b1;
                    pc_code = k;
                    pc_x    = SPAWN_COL;
                    pc_y    = 0;
                    live    = 1'b1;
                end
            end
            if (!ok) begin
                errors++;
                $display("Spawned piece matches none of the seven spawn patterns");
            end
        end
    endtask

    task automatic play_game;
        logic ok;
        logic landed;
        logic over;
        int   r;
        int   n;
        int   target;
        over = 1'b0;
        for (int p = 0; p < MAX_PIECES && !over; p++) begin
            identify_spawn(ok);
            if (!ok) return;
            post_check;
            if (p < STEERED) begin
                r = $random(seed);
                for (int i = 0; i < (r & 3); i++) rotate_piece(r[4 + i]);
                target = targets[p % 10];
                // Extra presses against a wall must leave the piece in place
                for (int i = 0; i < 6; i++) begin
                    if (target != pc_x) move_piece(target < pc_x ? -1 : 1);
                end
            end
            landed = 1'b0;
            for (int i = 0; i < BOARD_ROWS + 2 && !landed; i++) drop_piece(landed);
            if (exp_gameover) begin
                // Frozen board after game over
                repeat (50) @(negedge clk);
                post_check;
                over = 1'b1;
            end else begin
                model     = compact(model, n);
                exp_score = (exp_score + n > 1023) ? 1023 : exp_score + n;
                // Cleared board shows alone in the spawn cycle
                repeat (LOCK_CYCLE + LAND_TO_SPAWN - PRESS_CYCLES) @(negedge clk);
                post_check;
            end
        end
        if (!over) begin
            errors++;
            $display("Game never reached game over");
        end
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        check_req    = 1'b0;
        seed         = 32'h8552_a3c7;
        model        = '0;
        exp_score    = 0;
        exp_gameover = 1'b0;
        live         = 1'b0;
        start        = 1'b0;
        left         = 1'b0;
        right        = 1'b0;
        rot_cw       = 1'b0;
        rot_ccw      = 1'b0;
        tick         = 1'b0;
        reset        = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        post_check;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        play_game;
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
design/tetris_pkg.sv
design/input_sync.sv
design/game_ctrl.sv
design/piece_rom.sv
design/board_store.sv
design/line_clear.sv
design/tetris_top.sv
testbench/tetris_sva.sv
testbench/tb_tetris.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f all.f --top-module tb_tetris -Mdir obj_dir
	./obj_dir/Vtb_tetris > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi; \
	test $$status -eq 0

clean:
	rm -rf obj_dir sim.log
